// ==== src/cachePkg.sv ====
`default_nettype none

package cachePkg;

  // pipeline address and data word
  localparam int ADDR_W   = 32;
  localparam int XLEN     = 64;

  // address split, tag | index | offset
  localparam int OFFSET_W = 5;
  localparam int INDEX_W  = 6;
  localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

  // 32-byte line, refilled in four bus beats
  localparam int LINE_W   = 256;
  localparam int BEATS    = LINE_W / XLEN;

  // field view of a request address
  typedef struct packed {
    logic [TAG_W-1:0]    tag;
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-1:0] offset;
  } cacheAddrT;

  // controller states
  typedef enum logic [2:0] {
    Idle,
    Compare,
    Miss,
    Fetch,
    Refill
  } cacheStateT;

  // burst read request, beat count minus one
  typedef struct packed {
    logic [ADDR_W-1:0] lineAddr;
    logic [7:0]        beatLen;
  } busReqT;

  // one hit bit per way
  typedef struct packed {
    logic way1;
    logic way0;
  } wayHitT;

endpackage

`default_nettype wire

// ==== src/cacheDataRam.sv ====
`timescale 1ns/1ps
`default_nettype none

module cacheDataRam #(
  parameter int DEPTH = 64,
  parameter int WIDTH = 128
) (
  input  wire                     clk,
  input  wire                     en_i,
  input  wire                     we_i,
  input  wire [$clog2(DEPTH)-1:0] addr_i,
  input  wire [WIDTH-1:0]         wdata_i,
  output logic [WIDTH-1:0]        rdata_o
);

  logic [WIDTH-1:0] mem [DEPTH];

  // single port, read data held while not read
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        mem[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/cacheCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module cacheCtrl (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 valid_i,
  input  wire                 stallN_i,
  input  wire cachePkg::cacheAddrT addr_i,
  input  wire cachePkg::wayHitT    hit_i,
  input  wire                 rdReady_i,
  input  wire                 dataValid_i,
  input  wire                 rdLast_i,
  output logic                addrOk_o,
  output logic                dataOk_o,
  output logic                dataNotOk_o,
  output logic                rdValid_o,
  output cachePkg::busReqT    busReq_o,
  output cachePkg::cacheAddrT reqAddr_o,
  output logic                ramEn_o,
  output logic                fetchActive_o,
  output logic                refill_o,
  output logic                victimSample_o
);
  import cachePkg::*;

  cacheStateT state;
  cacheStateT stateNext;
  logic       anyHit;
  logic       accept;
  logic       inCompare;

  // hit bits refer to the latched request
  assign anyHit    = hit_i.way0 | hit_i.way1;
  assign inCompare = (state == Compare);

  // take a new address in idle, or right behind a hit
  assign addrOk_o = stallN_i && ((state == Idle) || (inCompare && anyHit));
  assign accept   = valid_i && addrOk_o;

  // data RAMs read at the new index in the accepting cycle
  assign ramEn_o = accept;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= Idle;
    end else begin
      state <= stateNext;
    end
  end

  always_comb begin
    stateNext = state;
    case (state)
      Idle: begin
        if (accept) begin
          stateNext = Compare;
        end
      end
      Compare: begin
        // miss goes to the bus, a hit may chain the next request
        if (!anyHit) begin
          stateNext = Miss;
        end else if (!accept) begin
          stateNext = Idle;
        end
      end
      Miss: begin
        if (rdReady_i) begin
          stateNext = Fetch;
        end
      end
      Fetch: begin
        if (dataValid_i && rdLast_i) begin
          stateNext = Refill;
        end
      end
      Refill: begin
        stateNext = Idle;
      end
      default: begin
        stateNext = Idle;
      end
    endcase
  end

  // request latch, address only
  always_ff @(posedge clk) begin
    if (accept) begin
      reqAddr_o <= addr_i;
    end
  end

  // responses toward the pipeline
  assign dataOk_o    = (inCompare && anyHit) || (state == Refill);
  assign dataNotOk_o = (inCompare && !anyHit) || (state == Miss) || (state == Fetch);

  // one request strobe once the bus is ready
  assign rdValid_o = (state == Miss) && rdReady_i;

  // refill sequencing for buffer and tag store
  assign fetchActive_o  = (state == Fetch);
  assign victimSample_o = fetchActive_o && dataValid_i && rdLast_i;
  assign refill_o       = (state == Refill);

  // line aligned burst, four beats
  always_comb begin
    busReq_o.lineAddr = {reqAddr_o.tag, reqAddr_o.index, {OFFSET_W{1'b0}}};
    busReq_o.beatLen  = 8'(BEATS - 1);
  end

endmodule

`default_nettype wire

// ==== src/cacheTagStore.sv ====
`timescale 1ns/1ps
`default_nettype none

module cacheTagStore (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire cachePkg::cacheAddrT reqAddr_i,
  input  wire                      victimSample_i,
  input  wire                      refill_i,
  output cachePkg::wayHitT         hit_o,
  output logic                     victimWay_o
);
  import cachePkg::*;

  localparam int          SETS_N    = 2 ** INDEX_W;
  localparam logic [15:0] LFSR_SEED = 16'hACE1;

  logic [TAG_W-1:0]  tagWay0 [SETS_N];
  logic [TAG_W-1:0]  tagWay1 [SETS_N];
  logic [SETS_N-1:0] validWay0;
  logic [SETS_N-1:0] validWay1;
  logic [15:0]       lfsr;
  logic              lfsrFb;

  // both ways looked up at the latched index
  assign hit_o.way0 = validWay0[reqAddr_i.index] && (tagWay0[reqAddr_i.index] == reqAddr_i.tag);
  assign hit_o.way1 = validWay1[reqAddr_i.index] && (tagWay1[reqAddr_i.index] == reqAddr_i.tag);

  // taps 16,14,13,11, maximal length
  assign lfsrFb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

  // free running, victim frozen on the last beat
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lfsr        <= LFSR_SEED;
      victimWay_o <= 1'b0;
    end else begin
      lfsr <= {lfsr[14:0], lfsrFb};
      if (victimSample_i) begin
        victimWay_o <= lfsr[0];
      end
    end
  end

  // valid bits, all lines empty after reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validWay0 <= '0;
      validWay1 <= '0;
    end else if (refill_i) begin
      if (victimWay_o) begin
        validWay1[reqAddr_i.index] <= 1'b1;
      end else begin
        validWay0[reqAddr_i.index] <= 1'b1;
      end
    end
  end

  // tag written in the refill cycle
  always_ff @(posedge clk) begin
    if (refill_i) begin
      if (victimWay_o) begin
        tagWay1[reqAddr_i.index] <= reqAddr_i.tag;
      end else begin
        tagWay0[reqAddr_i.index] <= reqAddr_i.tag;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/refillBuffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module refillBuffer (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire                         fetchActive_i,
  input  wire                         dataValid_i,
  input  wire [cachePkg::XLEN-1:0]    rdData_i,
  output logic [cachePkg::LINE_W-1:0] line_o
);
  import cachePkg::*;

  logic [1:0] beatCnt;
  logic       beatTake;

  // a beat counts only while fetching
  assign beatTake = fetchActive_i && dataValid_i;

  // slot pointer, back to zero outside fetch
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (!fetchActive_i) begin
      beatCnt <= '0;
    end else if (dataValid_i) begin
      beatCnt <= beatCnt + 2'd1;
    end
  end

  // beat n lands in word n of the line
  // untouched in refill, so the line stays stable
  always_ff @(posedge clk) begin
    if (beatTake) begin
      line_o[beatCnt*XLEN +: XLEN] <= rdData_i;
    end
  end

endmodule

`default_nettype wire

// ==== src/l1Cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module l1Cache #(
  parameter int SETS   = 64,
  parameter int HALF_W = 128
) (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire [cachePkg::ADDR_W-1:0]   addr_i,
  input  wire                          valid_i,
  input  wire                          stallN_i,
  output logic                         addrOk_o,
  output logic                         dataOk_o,
  output logic                         dataNotOk_o,
  output logic [cachePkg::XLEN-1:0]    rdData_o,
  output logic                         rdValid_o,
  output cachePkg::busReqT             busReq_o,
  input  wire                          rdReady_i,
  input  wire                          rdLast_i,
  input  wire [cachePkg::XLEN-1:0]     busData_i,
  input  wire                          dataValid_i
);
  import cachePkg::*;

  cacheAddrT          pipeAddr;
  cacheAddrT          reqAddr;
  wayHitT             wayHit;
  logic               ramEn;
  logic               fetchActive;
  logic               refill;
  logic               victimSample;
  logic               victimWay;
  logic [INDEX_W-1:0] ramAddr;
  logic [LINE_W-1:0]  refillLine;
  logic [LINE_W-1:0]  srcLine;
  logic [1:0]         wordSel;
  wire  [LINE_W-1:0]  wayLine [2];

  assign pipeAddr = addr_i;

  // accepted index for reads, latched index while refilling
  assign ramAddr = refill ? reqAddr.index : pipeAddr.index;

  cacheCtrl u_cacheCtrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .valid_i        (valid_i),
    .stallN_i       (stallN_i),
    .addr_i         (pipeAddr),
    .hit_i          (wayHit),
    .rdReady_i      (rdReady_i),
    .dataValid_i    (dataValid_i),
    .rdLast_i       (rdLast_i),
    .addrOk_o       (addrOk_o),
    .dataOk_o       (dataOk_o),
    .dataNotOk_o    (dataNotOk_o),
    .rdValid_o      (rdValid_o),
    .busReq_o       (busReq_o),
    .reqAddr_o      (reqAddr),
    .ramEn_o        (ramEn),
    .fetchActive_o  (fetchActive),
    .refill_o       (refill),
    .victimSample_o (victimSample)
  );

  cacheTagStore u_cacheTagStore (
    .clk            (clk),
    .rst_n          (rst_n),
    .reqAddr_i      (reqAddr),
    .victimSample_i (victimSample),
    .refill_i       (refill),
    .hit_o          (wayHit),
    .victimWay_o    (victimWay)
  );

  refillBuffer u_refillBuffer (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetchActive_i (fetchActive),
    .dataValid_i   (dataValid_i),
    .rdData_i      (busData_i),
    .line_o        (refillLine)
  );

  // two halves per way, the victim way takes the whole line
  for (genvar way = 0; way < 2; way++) begin : g_way
    logic              wayWe;
    logic [HALF_W-1:0] halfLo;
    logic [HALF_W-1:0] halfHi;

    assign wayWe        = refill && (victimWay == 1'(way));
    assign wayLine[way] = {halfHi, halfLo};

    cacheDataRam #(
      .DEPTH (SETS),
      .WIDTH (HALF_W)
    ) u_ramLo (
      .clk     (clk),
      .en_i    (ramEn || wayWe),
      .we_i    (wayWe),
      .addr_i  (ramAddr),
      .wdata_i (refillLine[HALF_W-1:0]),
      .rdata_o (halfLo)
    );

    cacheDataRam #(
      .DEPTH (SETS),
      .WIDTH (HALF_W)
    ) u_ramHi (
      .clk     (clk),
      .en_i    (ramEn || wayWe),
      .we_i    (wayWe),
      .addr_i  (ramAddr),
      .wdata_i (refillLine[2*HALF_W-1:HALF_W]),
      .rdata_o (halfHi)
    );
  end

  // refill answers from the buffer, otherwise the hit way
  assign srcLine  = refill ? refillLine : (wayHit.way1 ? wayLine[1] : wayLine[0]);
  assign wordSel  = reqAddr.offset[OFFSET_W-1:3];
  assign rdData_o = srcLine[wordSel*XLEN +: XLEN];

endmodule

`default_nettype wire

// ==== bench/l1CacheMem.sv ====
`timescale 1ns/1ps
`default_nettype none

module l1CacheMem (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       slow_i,
  input  wire                       rdValid_i,
  input  wire cachePkg::busReqT     busReq_i,
  output logic                      rdReady_o,
  output logic                      dataValid_o,
  output logic                      rdLast_o,
  output logic [cachePkg::XLEN-1:0] rdData_o
);
  import cachePkg::*;

  logic              reqSeen;
  logic [ADDR_W-1:0] reqLine;

  // request strobe caught on the rising edge, seen at the next falling edge
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reqSeen <= 1'b0;
    end else begin
      reqSeen <= rdValid_i;
      if (rdValid_i) begin
        reqLine <= busReq_i.lineAddr;
      end
    end
  end

  // bus side, everything driven on the falling edge
  initial begin : serveBursts
    logic [ADDR_W-1:0] beatAddr;
    rdReady_o   = 1'b0;
    dataValid_o = 1'b0;
    rdLast_o    = 1'b0;
    rdData_o    = '0;
    wait (rst_n);
    @(negedge clk);
    forever begin
      // ready after a random delay in slow mode
      repeat (slow_i ? $urandom_range(0, 5) : 0) @(negedge clk);
      rdReady_o = 1'b1;
      @(negedge clk);
      while (!reqSeen) begin
        @(negedge clk);
      end
      rdReady_o = 1'b0;
      beatAddr  = reqLine;
      for (int beat = 0; beat < BEATS; beat++) begin
        // optional gap before each beat
        repeat (slow_i ? $urandom_range(0, 2) : 0) @(negedge clk);
        dataValid_o = 1'b1;
        rdLast_o    = (beat == BEATS - 1);
        // word value is its address and the inverse
        rdData_o    = {beatAddr, ~beatAddr};
        @(negedge clk);
        dataValid_o = 1'b0;
        rdLast_o    = 1'b0;
        beatAddr    = beatAddr + 8;
      end
    end
  end

endmodule

`default_nettype wire

// ==== bench/l1CacheTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module l1CacheTb;
  import cachePkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int N_COLD     = 4;
  localparam int N_HIT      = 32;
  localparam int N_CONF     = 60;
  localparam int N_BP       = 60;
  localparam int REQ_TOTAL  = N_COLD + N_HIT + N_CONF + N_BP;

  logic              clk;
  logic              rst_n;
  logic [ADDR_W-1:0] addr;
  logic              valid;
  logic              stallN;
  logic              addrOk;
  logic              dataOk;
  logic              dataNotOk;
  logic [XLEN-1:0]   rdData;
  logic              rdValid;
  busReqT            busReq;
  logic              rdReady;
  logic              rdLast;
  logic [XLEN-1:0]   busData;
  logic              dataValid;
  logic              slowBus;
  logic              stallMode;

  // outstanding requests in arrival order
  logic [ADDR_W-1:0] addrQ [$];
  int                cycleQ [$];
  int                cycle;
  int                acceptCount;
  int                respCount;
  int                missCount;
  int                burstTotal;
  int                burstCnt;
  logic              sawMiss;
  logic              lastMiss;
  int                errCount;
  int                testErrBase;
  int                testsPassed;
  int                testsFailed;
  int                seedVal;

  l1Cache #(
    .SETS   (64),
    .HALF_W (128)
  ) u_l1Cache (
    .clk         (clk),
    .rst_n       (rst_n),
    .addr_i      (addr),
    .valid_i     (valid),
    .stallN_i    (stallN),
    .addrOk_o    (addrOk),
    .dataOk_o    (dataOk),
    .dataNotOk_o (dataNotOk),
    .rdData_o    (rdData),
    .rdValid_o   (rdValid),
    .busReq_o    (busReq),
    .rdReady_i   (rdReady),
    .rdLast_i    (rdLast),
    .busData_i   (busData),
    .dataValid_i (dataValid)
  );

  l1CacheMem u_l1CacheMem (
    .clk         (clk),
    .rst_n       (rst_n),
    .slow_i      (slowBus),
    .rdValid_i   (rdValid),
    .busReq_i    (busReq),
    .rdReady_o   (rdReady),
    .dataValid_o (dataValid),
    .rdLast_o    (rdLast),
    .rdData_o    (busData)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // expected bus word at a byte address
  function automatic logic [XLEN-1:0] memWord(input logic [ADDR_W-1:0] byteAddr);
    return {byteAddr, ~byteAddr};
  endfunction

  // few tags on few sets so lines fight over the two ways
  function automatic logic [ADDR_W-1:0] conflictAddr(input int tags, input int sets);
    cacheAddrT a;
    a.tag    = TAG_W'($urandom_range(0, tags - 1) + 'h40);
    a.index  = INDEX_W'($urandom_range(0, sets - 1));
    a.offset = OFFSET_W'($urandom_range(0, 31));
    return a;
  endfunction

  task automatic reportError(input string msg);
    errCount++;
    $display("error at %0t: %s", $time, msg);
  endtask

  task automatic checkWord(input string name, input logic [XLEN-1:0] got,
                           input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      errCount++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic checkBusReq(input string name, input busReqT got, input busReqT exp);
    if (got !== exp) begin
      errCount++;
      $display("mismatch at %0t: %s got %h/%0d expected %h/%0d", $time, name,
               got.lineAddr, got.beatLen, exp.lineAddr, exp.beatLen);
    end
  endtask

  task automatic checkStrobe(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errCount++;
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // one scoreboard step per cycle in the low phase
  task automatic scoreCycle();
    logic [ADDR_W-1:0] frontAddr;
    int                acceptAt;
    busReqT            expReq;
    cycle++;
    if (dataOk && dataNotOk) begin
      reportError("dataOk_o and dataNotOk_o high in the same cycle");
    end
    if (!stallN) begin
      checkStrobe("addrOk_o", addrOk, 1'b0);
    end
    if (rdValid) begin
      burstCnt++;
      burstTotal++;
      if (addrQ.size() == 0) begin
        reportError("rdValid_o with no request pending");
      end else begin
        expReq.lineAddr = {addrQ[0][ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        expReq.beatLen  = 8'd3;
        checkBusReq("busReq_o", busReq, expReq);
      end
    end
    if (dataNotOk) begin
      if (addrQ.size() == 0) begin
        reportError("dataNotOk_o with no request pending");
      end
      sawMiss = 1'b1;
    end
    if (dataOk) begin
      if (addrQ.size() == 0) begin
        reportError("dataOk_o with no request pending");
      end else begin
        frontAddr = addrQ.pop_front();
        acceptAt  = cycleQ.pop_front();
        checkWord("rdData_o", rdData, memWord({frontAddr[ADDR_W-1:3], 3'b000}));
        if (sawMiss) begin
          missCount++;
          if (burstCnt != 1) begin
            reportError($sformatf("miss at %h issued %0d bursts", frontAddr, burstCnt));
          end
        end else if (cycle != acceptAt + 1 || burstCnt != 0) begin
          reportError($sformatf("hit at %h was late or started a burst", frontAddr));
        end
        lastMiss = sawMiss;
        sawMiss  = 1'b0;
        burstCnt = 0;
        respCount++;
      end
    end else if (sawMiss && !dataNotOk) begin
      // a pending miss keeps dataNotOk_o up until its answer
      reportError("dataNotOk_o dropped while a miss was pending");
    end else if (!dataNotOk && addrQ.size() != 0 && cycle == cycleQ[0] + 1) begin
      reportError("no response one cycle after accept");
    end
    // accept happens on the coming rising edge
    if (valid && addrOk) begin
      addrQ.push_back(addr);
      cycleQ.push_back(cycle);
      acceptCount++;
    end
  endtask

  always @(negedge clk) begin
    #1;
    if (rst_n) begin
      scoreCycle();
    end
  end

  // random pipeline stall in the back-pressure test
  always @(negedge clk) begin
    stallN = stallMode ? ($urandom_range(0, 3) != 0) : 1'b1;
  end

  // drive a request and hold it until addrOk_o
  task automatic issueReq(input logic [ADDR_W-1:0] reqAddr, output int tries);
    tries = 0;
    @(negedge clk);
    valid = 1'b1;
    addr  = reqAddr;
    #1;
    tries++;
    while (addrOk !== 1'b1) begin
      @(negedge clk);
      #1;
      tries++;
    end
  endtask

  task automatic drainReqs();
    @(negedge clk);
    valid = 1'b0;
    while (respCount != acceptCount) begin
      @(negedge clk);
    end
  endtask

  task automatic beginTest();
    testErrBase = errCount;
  endtask

  task automatic finishTest(input string name, input int reqs);
    if (errCount == testErrBase) begin
      testsPassed++;
      $display("test %s ok, %0d requests", name, reqs);
    end else begin
      testsFailed++;
      $display("test %s failed with %0d errors", name, errCount - testErrBase);
    end
  endtask

  // watchdog allows 200 cycles per request
  initial begin
    #(CLK_PERIOD * 200 * REQ_TOTAL);
    $display("watchdog expired after %0d cycles, requests still outstanding",
             200 * REQ_TOTAL);
    $display("Testbench failed");
    $finish;
  end

  initial begin : mainSeq
    int tries;
    int missBase;
    int burstBase;
    seedVal     = 48;
    void'($urandom(seedVal));
    clk         = 1'b0;
    rst_n       = 1'b0;
    addr        = '0;
    valid       = 1'b0;
    stallN      = 1'b1;
    slowBus     = 1'b0;
    stallMode   = 1'b0;
    cycle       = 0;
    acceptCount = 0;
    respCount   = 0;
    missCount   = 0;
    burstTotal  = 0;
    burstCnt    = 0;
    sawMiss     = 1'b0;
    lastMiss    = 1'b0;
    errCount    = 0;
    testsPassed = 0;
    testsFailed = 0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    // idle outputs right after reset
    beginTest();
    #1;
    checkStrobe("dataOk_o", dataOk, 1'b0);
    checkStrobe("dataNotOk_o", dataNotOk, 1'b0);
    checkStrobe("rdValid_o", rdValid, 1'b0);
    checkStrobe("addrOk_o", addrOk, 1'b1);
    finishTest("reset", 0);

    // one first touch per line on distinct sets
    beginTest();
    for (int i = 0; i < N_COLD; i++) begin
      issueReq(32'h0000_1000 + i * 32 + i * 8, tries);
      drainReqs();
      checkStrobe("dataNotOk_o seen", lastMiss, 1'b1);
    end
    finishTest("coldMiss", N_COLD);

    // every word of the filled lines twice with chained accepts
    beginTest();
    missBase  = missCount;
    burstBase = burstTotal;
    for (int pass = 0; pass < 2; pass++) begin
      for (int i = 0; i < N_COLD; i++) begin
        for (int w = 0; w < 4; w++) begin
          issueReq(32'h0000_1000 + i * 32 + w * 8 + w, tries);
          if (tries != 1) begin
            reportError("hit request was not accepted back to back");
          end
        end
      end
    end
    drainReqs();
    if (missCount != missBase || burstTotal != burstBase) begin
      reportError("a filled line missed or started a burst");
    end
    finishTest("hits", N_HIT);

    beginTest();
    for (int i = 0; i < N_CONF; i++) begin
      issueReq(conflictAddr(6, 2), tries);
    end
    drainReqs();
    finishTest("conflicts", N_CONF);

    // slow bus, beat gaps, stalls and idle gaps on valid
    beginTest();
    slowBus   = 1'b1;
    stallMode = 1'b1;
    for (int i = 0; i < N_BP; i++) begin
      if ($urandom_range(0, 3) == 0) begin
        @(negedge clk);
        valid = 1'b0;
      end
      issueReq(conflictAddr(5, 4), tries);
    end
    drainReqs();
    slowBus   = 1'b0;
    stallMode = 1'b0;
    finishTest("backPressure", N_BP);

    $display("%0d tests passed, %0d tests failed, %0d errors",
             testsPassed, testsFailed, errCount);
    if (testsFailed == 0 && errCount == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== l1Cache.f ====
src/cachePkg.sv
src/cacheDataRam.sv
src/cacheCtrl.sv
src/cacheTagStore.sv
src/refillBuffer.sv
src/l1Cache.sv
bench/l1CacheMem.sv
bench/l1CacheTb.sv
